// File: common/kbd_pkg.sv
/*
 Shared constants and types for the receive-only PS/2 keyboard front end.
 Scan codes are Scan Code Set 2. Only the 19 keys listed here are tracked.
*/
package kbd_pkg;

    // Tracked key set
    localparam int NUM_KEYS = 19;

    // Key index, digits 0 to 9 sit at indices 0 to 9
    typedef logic [4:0] key_idx_t;
    // One bit per key index
    typedef logic [NUM_KEYS-1:0] key_vec_t;
    // Byte as it comes off the PS/2 line
    typedef logic [7:0] scan_byte_t;

    // Indices of the non-digit keys
    localparam key_idx_t KEY_MINUS    = 5'd10;
    localparam key_idx_t KEY_LBRACKET = 5'd11;
    localparam key_idx_t KEY_RBRACKET = 5'd12;
    localparam key_idx_t KEY_SPACE    = 5'd13;
    localparam key_idx_t KEY_ENTER    = 5'd14;
    localparam key_idx_t KEY_LEFT     = 5'd15;
    localparam key_idx_t KEY_RIGHT    = 5'd16;
    localparam key_idx_t KEY_UP       = 5'd17;
    localparam key_idx_t KEY_DOWN     = 5'd18;

    // Plain make codes, digits on the main row
    localparam scan_byte_t DIGIT0_CODE = 8'h45;
    localparam scan_byte_t DIGIT1_CODE = 8'h16;
    localparam scan_byte_t DIGIT2_CODE = 8'h1E;
    localparam scan_byte_t DIGIT3_CODE = 8'h26;
    localparam scan_byte_t DIGIT4_CODE = 8'h25;
    localparam scan_byte_t DIGIT5_CODE = 8'h2E;
    localparam scan_byte_t DIGIT6_CODE = 8'h36;
    localparam scan_byte_t DIGIT7_CODE = 8'h3D;
    localparam scan_byte_t DIGIT8_CODE = 8'h3E;
    localparam scan_byte_t DIGIT9_CODE = 8'h46;

    localparam scan_byte_t MINUS_CODE    = 8'h4E;
    localparam scan_byte_t LBRACKET_CODE = 8'h54;
    localparam scan_byte_t RBRACKET_CODE = 8'h5B;
    localparam scan_byte_t SPACE_CODE    = 8'h29;
    localparam scan_byte_t ENTER_CODE    = 8'h5A;

    // Arrow codes, only valid after the E0 prefix
    // Without E0 these collide with the keypad keys
    localparam scan_byte_t LEFT_CODE  = 8'h6B;
    localparam scan_byte_t RIGHT_CODE = 8'h74;
    localparam scan_byte_t UP_CODE    = 8'h75;
    localparam scan_byte_t DOWN_CODE  = 8'h72;

    // Prefix bytes
    localparam scan_byte_t EXT_PREFIX   = 8'hE0;
    localparam scan_byte_t BREAK_PREFIX = 8'hF0;

    // Receiver timing
    localparam int SYNC_STAGES       = 2;
    localparam int FRAME_BITS        = 11;
    localparam int RX_TIMEOUT_CYCLES = 8192;
    localparam int RX_TIMEOUT_W      = $clog2(RX_TIMEOUT_CYCLES);

    // Bit position inside a frame, 0 to 10
    typedef logic [3:0] bit_cnt_t;
    // System clocks since the last PS/2 clock edge
    typedef logic [RX_TIMEOUT_W-1:0] idle_cnt_t;

    // Received byte with its one-cycle strobe
    typedef struct packed {
        logic       valid;
        scan_byte_t data;
    } rx_byte_t;

    // Key make or break event, make high for a press
    typedef struct packed {
        logic     valid;
        logic     make;
        key_idx_t key;
    } key_event_t;

    // Prefix tracking for the decoder
    typedef enum logic [1:0] {
        MAKE,
        BREAK,
        EXT_MAKE,
        EXT_BREAK
    } decode_state_e;

endpackage

// File: hw/ps2_rx/ps2_rx.sv
/*
 Receive-only PS/2 frame deserialiser. Lines are sampled, never driven.
 A partial frame with no clock edge for RX_TIMEOUT_CYCLES is dropped.
*/
`timescale 1ns/10ps

module ps2_rx (
    input  logic              CLOCK_50,
    input  logic              reset,
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    output kbd_pkg::rx_byte_t rx_byte,
    output logic              frame_error
);

    // Synchroniser chains, newest sample enters at bit 0
    logic [kbd_pkg::SYNC_STAGES-1:0] clk_sync;
    logic [kbd_pkg::SYNC_STAGES-1:0] dat_sync;
    // Previous synchronised clock level for edge detection
    logic clk_prev;
    logic clk_fall;
    logic dat_bit;

    // Frame assembly state
    kbd_pkg::bit_cnt_t  bit_cnt;
    kbd_pkg::idle_cnt_t idle_cnt;
    // Start, eight data bits and parity, start ends up in bit 0
    logic [kbd_pkg::FRAME_BITS-2:0] frame_sr;
    logic last_bit;
    logic frame_ok;

    // Output registers
    logic                byte_valid;
    kbd_pkg::scan_byte_t byte_data;

    // Both lines idle high, so the chains come out of reset high
    // to avoid a false falling edge
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[kbd_pkg::SYNC_STAGES-2:0], ps2_clk};
            dat_sync <= {dat_sync[kbd_pkg::SYNC_STAGES-2:0], ps2_dat};
            clk_prev <= clk_sync[kbd_pkg::SYNC_STAGES-1];
        end
    end

    // Keyboard changes data on the rising edge, so sample on the falling one
    assign clk_fall = clk_prev & ~clk_sync[kbd_pkg::SYNC_STAGES-1];
    assign dat_bit  = dat_sync[kbd_pkg::SYNC_STAGES-1];

    // Edge that carries the stop bit
    assign last_bit = clk_fall &&
                      (bit_cnt == kbd_pkg::bit_cnt_t'(kbd_pkg::FRAME_BITS - 1));

    // Start low, odd parity over data plus parity bit, stop high
    assign frame_ok = ~frame_sr[0] &
                      (^frame_sr[kbd_pkg::FRAME_BITS-2:1]) &
                      dat_bit;

    // Bit counter and mid-frame idle timer
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
        end else if (clk_fall) begin
            idle_cnt <= '0;
            if (last_bit) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else if (bit_cnt != '0) begin
            // Keyboard stalled mid-frame, throw the partial frame away
            if (idle_cnt == kbd_pkg::idle_cnt_t'(kbd_pkg::RX_TIMEOUT_CYCLES - 1)) begin
                bit_cnt  <= '0;
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // LSB first, shift right so the start bit lands in bit 0
    // after ten edges; the stop bit is checked straight off the line
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            frame_sr <= {dat_bit, frame_sr[kbd_pkg::FRAME_BITS-2:1]};
        end
    end

    // One-cycle strobes, issued the cycle after the stop edge
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= last_bit & frame_ok;
            frame_error <= last_bit & ~frame_ok;
        end
    end

    // Data bits sit between start and parity
    always_ff @(posedge CLOCK_50) begin
        if (last_bit) begin
            byte_data <= frame_sr[8:1];
        end
    end

    assign rx_byte = '{valid: byte_valid, data: byte_data};

    // Frames are hundreds of cycles apart, strobes never stretch
    a_valid_one_cycle: assert property (
        @(posedge CLOCK_50) disable iff (!reset)
        rx_byte.valid |=> !rx_byte.valid
    );

    a_error_one_cycle: assert property (
        @(posedge CLOCK_50) disable iff (!reset)
        frame_error |=> !frame_error
    );

endmodule

// File: hw/scan_decoder/scan_decoder.sv
/*
 Scan Code Set 2 decoder for E0 and F0 prefixes. Unmapped codes and
 multi-byte sequences such as print screen and pause produce no event.
*/
`timescale 1ns/10ps

module scan_decoder (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  kbd_pkg::rx_byte_t   rx_byte,
    output kbd_pkg::key_event_t key_event
);

    kbd_pkg::decode_state_e state;

    // Byte classification
    logic is_prefix;
    logic is_ext;
    logic is_make;

    // Table lookups
    logic              plain_hit;
    logic              arrow_hit;
    logic              hit;
    kbd_pkg::key_idx_t plain_key;
    kbd_pkg::key_idx_t arrow_key;

    // Event registers
    logic              ev_valid;
    logic              ev_make;
    kbd_pkg::key_idx_t ev_key;

    assign is_prefix = (rx_byte.data == kbd_pkg::EXT_PREFIX) ||
                       (rx_byte.data == kbd_pkg::BREAK_PREFIX);
    assign is_ext    = (state == kbd_pkg::EXT_MAKE) || (state == kbd_pkg::EXT_BREAK);
    assign is_make   = (state == kbd_pkg::MAKE) || (state == kbd_pkg::EXT_MAKE);

    // Plain table, used in MAKE and BREAK
    always_comb begin
        plain_hit = 1'b1;
        plain_key = '0;
        case (rx_byte.data)
            kbd_pkg::DIGIT0_CODE:   plain_key = 5'd0;
            kbd_pkg::DIGIT1_CODE:   plain_key = 5'd1;
            kbd_pkg::DIGIT2_CODE:   plain_key = 5'd2;
            kbd_pkg::DIGIT3_CODE:   plain_key = 5'd3;
            kbd_pkg::DIGIT4_CODE:   plain_key = 5'd4;
            kbd_pkg::DIGIT5_CODE:   plain_key = 5'd5;
            kbd_pkg::DIGIT6_CODE:   plain_key = 5'd6;
            kbd_pkg::DIGIT7_CODE:   plain_key = 5'd7;
            kbd_pkg::DIGIT8_CODE:   plain_key = 5'd8;
            kbd_pkg::DIGIT9_CODE:   plain_key = 5'd9;
            kbd_pkg::MINUS_CODE:    plain_key = kbd_pkg::KEY_MINUS;
            kbd_pkg::LBRACKET_CODE: plain_key = kbd_pkg::KEY_LBRACKET;
            kbd_pkg::RBRACKET_CODE: plain_key = kbd_pkg::KEY_RBRACKET;
            kbd_pkg::SPACE_CODE:    plain_key = kbd_pkg::KEY_SPACE;
            kbd_pkg::ENTER_CODE:    plain_key = kbd_pkg::KEY_ENTER;
            default:                plain_hit = 1'b0;
        endcase
    end

    // Arrow table, only consulted after E0
    always_comb begin
        arrow_hit = 1'b1;
        arrow_key = '0;
        case (rx_byte.data)
            kbd_pkg::LEFT_CODE:  arrow_key = kbd_pkg::KEY_LEFT;
            kbd_pkg::RIGHT_CODE: arrow_key = kbd_pkg::KEY_RIGHT;
            kbd_pkg::UP_CODE:    arrow_key = kbd_pkg::KEY_UP;
            kbd_pkg::DOWN_CODE:  arrow_key = kbd_pkg::KEY_DOWN;
            default:             arrow_hit = 1'b0;
        endcase
    end

    assign hit = is_ext ? arrow_hit : plain_hit;

    // Prefix machine; any non-prefix byte ends the sequence
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            state <= kbd_pkg::MAKE;
        end else if (rx_byte.valid) begin
            if (rx_byte.data == kbd_pkg::EXT_PREFIX) begin
                state <= kbd_pkg::EXT_MAKE;
            end else if (rx_byte.data == kbd_pkg::BREAK_PREFIX) begin
                // F0 keeps the extended flag if E0 came first
                state <= is_ext ? kbd_pkg::EXT_BREAK : kbd_pkg::BREAK;
            end else begin
                state <= kbd_pkg::MAKE;
            end
        end
    end

    // Event strobe, one cycle after the byte
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= rx_byte.valid & ~is_prefix & hit;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rx_byte.valid) begin
            ev_make <= is_make;
            ev_key  <= is_ext ? arrow_key : plain_key;
        end
    end

    assign key_event = '{valid: ev_valid, make: ev_make, key: ev_key};

    // Tracker indexes its vectors directly with this
    a_key_in_range: assert property (
        @(posedge CLOCK_50) disable iff (!reset)
        key_event.valid |-> (key_event.key < kbd_pkg::NUM_KEYS)
    );

endmodule

// File: hw/key_tracker.sv
/*
 Per-key held flags and one-cycle press pulses.
 Held state is only as good as the break codes seen, so reset clears all keys.
*/
`timescale 1ns/10ps

module key_tracker (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  kbd_pkg::key_event_t key_event,
    output kbd_pkg::key_vec_t   held,
    output kbd_pkg::key_vec_t   pressed
);

    // Current key state
    kbd_pkg::key_vec_t held_q;
    // Held delayed by one cycle
    kbd_pkg::key_vec_t lock_q;

    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            held_q <= '0;
            lock_q <= '0;
        end else begin
            // Lock rises one cycle after held and falls one cycle after it
            lock_q <= held_q;
            // Make sets, break clears
            // Typematic repeats rewrite a 1, so no new pulse
            if (key_event.valid) begin
                held_q[key_event.key] <= key_event.make;
            end
        end
    end

    assign held = held_q;

    // Only the first held cycle has lock still low
    assign pressed = held_q & ~lock_q;

    // A make for a key that is still up gives its pulse on the next cycle
    a_pulse_after_make: assert property (
        @(posedge CLOCK_50) disable iff (!reset)
        (key_event.valid && key_event.make && !held[key_event.key])
            |=> pressed[$past(key_event.key)]
    );

endmodule

// File: hw/keyboard_tracker.sv
/*
 PS/2 keyboard front end top level, receive only.
 ps2_clk and ps2_dat are asynchronous inputs, frame_error is a one-cycle strobe.
*/
`timescale 1ns/10ps

module keyboard_tracker (
    input  logic              CLOCK_50,
    input  logic              reset,
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    output kbd_pkg::key_vec_t held,
    output kbd_pkg::key_vec_t pressed,
    output logic              frame_error
);

    // Byte stream from the receiver
    kbd_pkg::rx_byte_t   rx_byte;
    // Make and break events from the decoder
    kbd_pkg::key_event_t key_event;

    // Line sampling and frame checks
    ps2_rx u_ps2_rx (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .rx_byte     (rx_byte),
        .frame_error (frame_error)
    );

    // Prefix handling and key lookup
    scan_decoder u_scan_decoder (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .rx_byte   (rx_byte),
        .key_event (key_event)
    );

    // Held flags and press pulses
    key_tracker u_key_tracker (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .key_event (key_event),
        .held      (held),
        .pressed   (pressed)
    );

endmodule

// File: tests/ps2_device_model.sv
/*
 Behavioural PS/2 keyboard that sends device-to-host frames only.
 Lines change on falling CLOCK_50 edges, PS/2 half period is 20 system clocks.
*/
`timescale 1ns/10ps

module ps2_device_model (
    input  logic CLOCK_50,
    output logic ps2_clk,
    output logic ps2_dat
);

    // System clocks per PS/2 clock phase
    localparam int HALF_PERIOD = 20;

    // Both lines idle high
    initial begin
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
    end

    // Frame is start, eight data bits LSB first, odd parity, stop
    // A trunc_bits count from 1 to 10 stops after that many bits
    task automatic send_byte(input logic [7:0] data, input logic bad_parity,
                             input logic bad_stop, input int trunc_bits);
        logic [10:0] frame;
        int          n_bits;
        int          i;
        // Parity bit makes the count of ones odd, a flip breaks it
        frame  = {~bad_stop, (~^data) ^ bad_parity, data, 1'b0};
        n_bits = (trunc_bits > 0 && trunc_bits < 11) ? trunc_bits : 11;
        for (i = 0; i < n_bits; i++) begin
            // Data changes in the middle of the high phase
            @(negedge CLOCK_50);
            ps2_dat = frame[i];
            repeat (HALF_PERIOD / 2) @(negedge CLOCK_50);
            // Host samples on this falling edge
            ps2_clk = 1'b0;
            repeat (HALF_PERIOD) @(negedge CLOCK_50);
            ps2_clk = 1'b1;
            repeat (HALF_PERIOD / 2 - 1) @(negedge CLOCK_50);
        end
        // Release data back to idle, clock is already high
        @(negedge CLOCK_50);
        ps2_dat = 1'b1;
    endtask

endmodule

// File: tests/tb_keyboard_tracker.sv
/*
 Testbench for the PS/2 keyboard front end, driven through a behavioural keyboard.
 Steps run from a table, each checked for held keys, press pulses and frame errors.
*/
`timescale 1ns/10ps

module tb_keyboard_tracker;

    localparam int NUM_STEPS    = 16;
    localparam int MAX_BYTES    = 3;
    localparam int IDLE_CYCLES  = 50;
    // Eleven bits of two 20-clock phases each
    localparam int FRAME_CYCLES = 11 * 2 * 20;
    localparam int STEP_CYCLES  = MAX_BYTES * FRAME_CYCLES + IDLE_CYCLES;
    // Three times the longest steps, plus the truncated frame timeout and margin
    localparam int WATCHDOG_CYCLES = NUM_STEPS * STEP_CYCLES * 3 +
                                     2 * kbd_pkg::RX_TIMEOUT_CYCLES;

    // Error injection for one frame
    typedef struct packed {
        logic       bad_parity;
        logic       bad_stop;
        logic [3:0] trunc_bits;
    } frame_flags_t;

    logic              CLOCK_50;
    logic              reset;
    logic              ps2_clk;
    logic              ps2_dat;
    kbd_pkg::key_vec_t held;
    kbd_pkg::key_vec_t pressed;
    logic              frame_error;

    integer seed;

    // Stimulus table
    string             step_name  [NUM_STEPS];
    int                step_len   [NUM_STEPS];
    logic [7:0]        step_bytes [NUM_STEPS][MAX_BYTES];
    frame_flags_t      step_flags [NUM_STEPS];
    kbd_pkg::key_vec_t step_held  [NUM_STEPS];
    kbd_pkg::key_vec_t step_pulse [NUM_STEPS];
    int                step_errs  [NUM_STEPS];
    int                num_added;

    // Running totals from the monitor
    int pulse_cnt [kbd_pkg::NUM_KEYS];
    int error_cnt;

    keyboard_tracker UUT (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .held        (held),
        .pressed     (pressed),
        .frame_error (frame_error)
    );

    ps2_device_model kbd (
        .CLOCK_50 (CLOCK_50),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat)
    );

    always #4 CLOCK_50 = ~CLOCK_50;

    // Counts strobes sampled before the edge updates them
    always @(posedge CLOCK_50) begin
        if (!reset) begin
            error_cnt <= 0;
            for (int k = 0; k < kbd_pkg::NUM_KEYS; k++) begin
                pulse_cnt[k] <= 0;
            end
        end else begin
            if (frame_error) begin
                error_cnt <= error_cnt + 1;
            end
            for (int k = 0; k < kbd_pkg::NUM_KEYS; k++) begin
                if (pressed[k]) begin
                    pulse_cnt[k] <= pulse_cnt[k] + 1;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    function automatic kbd_pkg::key_vec_t key_bit(input int idx);
        return kbd_pkg::key_vec_t'(1) << idx;
    endfunction

    // Key codes of both tables and the two prefixes
    function automatic logic is_known_code(input logic [7:0] code);
        case (code)
            8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
            8'h4E, 8'h54, 8'h5B, 8'h29, 8'h5A,
            8'h6B, 8'h74, 8'h75, 8'h72,
            8'hE0, 8'hF0: return 1'b1;
            default:      return 1'b0;
        endcase
    endfunction

    function automatic logic [7:0] pick_unmapped();
        logic [7:0] code;
        code = $random(seed);
        while (is_known_code(code)) begin
            code = $random(seed);
        end
        return code;
    endfunction

    task automatic add_step(input string name, input int len, input logic [7:0] b0,
                            input logic [7:0] b1, input logic [7:0] b2,
                            input frame_flags_t flags, input kbd_pkg::key_vec_t exp_held,
                            input kbd_pkg::key_vec_t exp_pulse, input int exp_errs);
        step_name[num_added]     = name;
        step_len[num_added]      = len;
        step_bytes[num_added][0] = b0;
        step_bytes[num_added][1] = b1;
        step_bytes[num_added][2] = b2;
        step_flags[num_added]    = flags;
        step_held[num_added]     = exp_held;
        step_pulse[num_added]    = exp_pulse;
        step_errs[num_added]     = exp_errs;
        num_added++;
    endtask

    task automatic build_table();
        frame_flags_t      none;
        frame_flags_t      par_err;
        frame_flags_t      stop_err;
        frame_flags_t      trunc5;
        kbd_pkg::key_vec_t up_enter;
        none     = '0;
        par_err  = '{bad_parity: 1'b1, bad_stop: 1'b0, trunc_bits: 4'd0};
        stop_err = '{bad_parity: 1'b0, bad_stop: 1'b1, trunc_bits: 4'd0};
        trunc5   = '{bad_parity: 1'b0, bad_stop: 1'b0, trunc_bits: 4'd5};
        up_enter = key_bit(14) | key_bit(17);
        num_added = 0;
        // Space make then break, index 13
        add_step("space_make", 1, 8'h29, 8'h00, 8'h00, none, key_bit(13), key_bit(13), 0);
        add_step("space_break", 2, 8'hF0, 8'h29, 8'h00, none, '0, '0, 0);
        // Right arrow, index 16; a plain 74 is keypad 6 and untracked
        add_step("right_make", 2, 8'hE0, 8'h74, 8'h00, none, key_bit(16), key_bit(16), 0);
        add_step("right_break", 3, 8'hE0, 8'hF0, 8'h74, none, '0, '0, 0);
        add_step("keypad6_plain", 1, 8'h74, 8'h00, 8'h00, none, '0, '0, 0);
        // Several keys down together, typematic repeat gives no pulse
        add_step("digit1_make", 1, 8'h16, 8'h00, 8'h00, none, key_bit(1), key_bit(1), 0);
        add_step("enter_make", 1, 8'h5A, 8'h00, 8'h00, none,
                 key_bit(1) | key_bit(14), key_bit(14), 0);
        add_step("digit1_repeat", 1, 8'h16, 8'h00, 8'h00, none,
                 key_bit(1) | key_bit(14), '0, 0);
        add_step("up_make", 2, 8'hE0, 8'h75, 8'h00, none,
                 key_bit(1) | up_enter, key_bit(17), 0);
        add_step("digit1_break", 2, 8'hF0, 8'h16, 8'h00, none, up_enter, '0, 0);
        // Random codes outside both tables
        add_step("unmapped_a", 1, pick_unmapped(), 8'h00, 8'h00, none, up_enter, '0, 0);
        add_step("unmapped_b", 1, pick_unmapped(), 8'h00, 8'h00, none, up_enter, '0, 0);
        // Damaged frames are dropped with one error strobe each
        add_step("bad_parity", 1, 8'h45, 8'h00, 8'h00, par_err, up_enter, '0, 1);
        add_step("bad_stop", 1, 8'h46, 8'h00, 8'h00, stop_err, up_enter, '0, 1);
        // Partial frame is cleared by the idle timeout, next frame decodes
        add_step("truncated", 1, 8'h3D, 8'h00, 8'h00, trunc5, up_enter, '0, 0);
        add_step("digit7_make", 1, 8'h3D, 8'h00, 8'h00, none,
                 up_enter | key_bit(7), key_bit(7), 0);
    endtask

    task automatic run_step(input int s);
        int base_pulse [kbd_pkg::NUM_KEYS];
        int base_errs;
        int wait_cycles;
        base_errs = error_cnt;
        for (int k = 0; k < kbd_pkg::NUM_KEYS; k++) begin
            base_pulse[k] = pulse_cnt[k];
        end
        for (int b = 0; b < step_len[s]; b++) begin
            kbd.send_byte(step_bytes[s][b], step_flags[s].bad_parity,
                          step_flags[s].bad_stop, step_flags[s].trunc_bits);
        end
        wait_cycles = IDLE_CYCLES;
        if (step_flags[s].trunc_bits != '0) begin
            wait_cycles += kbd_pkg::RX_TIMEOUT_CYCLES;
        end
        repeat (wait_cycles) @(negedge CLOCK_50);
        check_value($sformatf("%s held", step_name[s]), step_held[s], held);
        for (int k = 0; k < kbd_pkg::NUM_KEYS; k++) begin
            check_value($sformatf("%s pulses key %0d", step_name[s], k),
                        step_pulse[s][k], pulse_cnt[k] - base_pulse[k]);
        end
        check_value($sformatf("%s frame errors", step_name[s]), step_errs[s],
                    error_cnt - base_errs);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("Run timed out after %0d clock cycles with tests unfinished",
                 WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main_seq
        CLOCK_50 = 1'b0;
        reset    = 1'b0;
        seed     = 32'h20dc;
        build_table();
        repeat (2) @(negedge CLOCK_50);
        reset = 1'b1;
        repeat (2) @(negedge CLOCK_50);
        check_value("after_reset held", '0, held);
        for (int s = 0; s < NUM_STEPS; s++) begin
            run_step(s);
        end
        // Keys are still held here, reset must clear them
        reset = 1'b0;
        repeat (2) @(negedge CLOCK_50);
        reset = 1'b1;
        @(negedge CLOCK_50);
        check_value("reset_clears held", '0, held);
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: filelist.f
common/kbd_pkg.sv
hw/ps2_rx/ps2_rx.sv
hw/scan_decoder/scan_decoder.sv
hw/key_tracker.sv
hw/keyboard_tracker.sv
tests/ps2_device_model.sv
tests/tb_keyboard_tracker.sv
